// ==== logic/forward_pkg.sv ====
// Packet layout for the forward-data generator.
// Shared by the FIFOs, the rebase stage and the top level.

package forward_pkg;

    // Field widths
    localparam int unsigned id_w   = 8;
    localparam int unsigned data_w = 32;

    typedef logic [id_w-1:0] fwd_id_t;

    // One forwarded packet, IDs in the upper bits
    typedef struct packed {
        fwd_id_t             from_id;
        fwd_id_t             to_id;
        logic [data_w-1:0]   data;
    } packet_t;

endpackage : forward_pkg

// ==== logic/gen_ctrl_pkg.sv ====
// Control-side definitions for the forward-data generator.
// Holds the job FSM states, FIFO sizing and the configuration word.

package gen_ctrl_pkg;

    // FIFO sizing
    localparam int unsigned fifo_depth  = 16;
    localparam int unsigned prog_thresh = 8;

    // Packet counter width
    localparam int unsigned count_w = 16;

    // Configuration returned after the setup pulse
    typedef struct packed {
        forward_pkg::fwd_id_t   forward_value;
        logic [count_w-1:0]     packet_count;
    } fwd_config_t;

    // Job FSM states
    typedef enum logic [3:0] {
        RESET,
        IDLE,
        SETUP_WAIT,
        SETUP_REQ,
        SETUP,
        START,
        BUSY,
        PAUSE,
        DONE
    } seq_state_t;

endpackage : gen_ctrl_pkg

// ==== logic/packet_fifo_if.sv ====
// Write and read sides of one packet FIFO.
// The top, the rebase stage and the sequencer each take the modport they need.

`timescale 1ns/1ps

interface packet_fifo_if;

    // Write side
    logic                   wr_en;
    forward_pkg::packet_t   din;
    logic                   full;
    logic                   prog_full;

    // Read side
    logic                   rd_en;
    forward_pkg::packet_t   dout;
    logic                   valid;
    logic                   empty;

    modport fifo (
        input  wr_en, din, rd_en,
        output full, prog_full, dout, valid, empty
    );

    modport writer (output wr_en, din, input full, prog_full);

    modport reader (output rd_en, input dout, valid, empty);

    // Observes the write side only
    modport monitor (input wr_en, prog_full);

endinterface : packet_fifo_if

// ==== logic/packet_fifo.sv ====
// Synchronous packet FIFO with registered read data.
// dout and valid follow a read request by one cycle; prog_full rises once
// the fill level reaches prog_thresh.

`timescale 1ns/1ps

module packet_fifo #(
    parameter int unsigned depth       = gen_ctrl_pkg::fifo_depth,
    parameter int unsigned prog_thresh = gen_ctrl_pkg::prog_thresh
) (
    input  logic            ap_clk,
    input  logic            areset_generator,
    packet_fifo_if.fifo     q
);

    localparam int unsigned          ptr_w      = $clog2(depth);
    localparam int unsigned          cnt_w      = $clog2(depth + 1);
    localparam logic [cnt_w-1:0]     full_level = cnt_w'(depth);
    localparam logic [cnt_w-1:0]     prog_level = cnt_w'(prog_thresh);
    localparam logic [ptr_w-1:0]     last_slot  = ptr_w'(depth - 1);

    forward_pkg::packet_t   mem [depth];
    logic [ptr_w-1:0]       wr_ptr_q;
    logic [ptr_w-1:0]       rd_ptr_q;
    logic [cnt_w-1:0]       count_q;
    logic                   do_wr;
    logic                   do_rd;

    assign do_wr = q.wr_en && !q.full;
    assign do_rd = q.rd_en && !q.empty;

    // Flags from the fill count
    assign q.empty     = (count_q == '0);
    assign q.full      = (count_q == full_level);
    assign q.prog_full = (count_q >= prog_level);

    // --------------------
    // Pointers and fill count
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            q.valid  <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= (wr_ptr_q == last_slot) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= (rd_ptr_q == last_slot) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            q.valid <= do_rd;
        end
    end

    // --------------------
    // Storage
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= q.din;
        end
        if (do_rd) begin
            q.dout <= mem[rd_ptr_q];
        end
    end

    // Both sides must respect the flags
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(q.wr_en && q.full))
        else $error("write while full");
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(q.rd_en && q.empty))
        else $error("read while empty");

endmodule : packet_fifo

// ==== logic/forward_rebase.sv ====
// Rebase stage between the input and output FIFOs.
// Keeps one packet in flight from its pop through rebase to its write.
// Forward IDs below forward_value saturate to zero.

`timescale 1ns/1ps

module forward_rebase (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    run,
    input  logic                    response_rd_en,
    input  forward_pkg::fwd_id_t    forward_value,
    packet_fifo_if.reader           in_q,
    packet_fifo_if.writer           out_q
);

    forward_pkg::packet_t   pkt_q;
    logic                   wr_q;
    logic                   in_flight_q;
    logic                   pop;

    function automatic forward_pkg::fwd_id_t rebase_id(
        input forward_pkg::fwd_id_t id,
        input forward_pkg::fwd_id_t base
    );
        rebase_id = (id >= base) ? id - base : '0;
    endfunction

    assign pop         = run && response_rd_en && !in_q.empty && !in_flight_q;
    assign in_q.rd_en  = pop;
    assign out_q.wr_en = wr_q;
    assign out_q.din   = pkt_q;

    // In flight from the pop until its write
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            in_flight_q <= 1'b0;
            wr_q        <= 1'b0;
        end else begin
            wr_q <= in_q.valid;
            if (pop) begin
                in_flight_q <= 1'b1;
            end else if (wr_q) begin
                in_flight_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (in_q.valid) begin
            pkt_q.from_id <= rebase_id(in_q.dout.from_id, forward_value);
            pkt_q.to_id   <= rebase_id(in_q.dout.to_id, forward_value);
            pkt_q.data    <= in_q.dout.data;
        end
    end

    assert property (@(posedge ap_clk) disable iff (areset_generator)
        out_q.wr_en |-> !out_q.full)
        else $error("output FIFO written while full");

endmodule : forward_rebase

// ==== logic/forward_sequencer.sv ====
// Job FSM of the forward-data generator.
// Requests the configuration, captures it, then holds run high in BUSY until
// packet_count packets have been written to the output FIFO.

`timescale 1ns/1ps

module forward_sequencer (
    input  logic                        ap_clk,
    input  logic                        areset_generator,
    input  logic                        descriptor_valid,
    input  logic                        config_rd_en,
    input  logic                        config_valid,
    input  gen_ctrl_pkg::fwd_config_t   config_word,
    packet_fifo_if.monitor              out_q,
    output logic                        run,
    output logic                        configure_memory_setup,
    output logic                        done,
    output forward_pkg::fwd_id_t        forward_value
);

    gen_ctrl_pkg::seq_state_t           state_q;
    gen_ctrl_pkg::seq_state_t           state_next;
    gen_ctrl_pkg::fwd_config_t          cfg_q;
    logic [gen_ctrl_pkg::count_w-1:0]   count_q;
    logic [gen_ctrl_pkg::count_w-1:0]   count_next;
    logic                               finished;

    // Include a write landing this cycle so run drops before another pop
    assign count_next = count_q + {{(gen_ctrl_pkg::count_w - 1){1'b0}}, out_q.wr_en};
    assign finished   = (count_next == cfg_q.packet_count);

    // --------------------
    // Next state
    always_comb begin
        state_next = state_q;
        case (state_q)
            gen_ctrl_pkg::RESET:      state_next = gen_ctrl_pkg::IDLE;
            gen_ctrl_pkg::IDLE: begin
                if (descriptor_valid) state_next = gen_ctrl_pkg::SETUP_WAIT;
            end
            gen_ctrl_pkg::SETUP_WAIT: begin
                if (config_rd_en) state_next = gen_ctrl_pkg::SETUP_REQ;
            end
            gen_ctrl_pkg::SETUP_REQ:  state_next = gen_ctrl_pkg::SETUP;
            gen_ctrl_pkg::SETUP: begin
                if (config_valid) state_next = gen_ctrl_pkg::START;
            end
            // A zero-count job skips BUSY entirely
            gen_ctrl_pkg::START: begin
                state_next = finished ? gen_ctrl_pkg::DONE : gen_ctrl_pkg::BUSY;
            end
            gen_ctrl_pkg::BUSY: begin
                if (finished) state_next = gen_ctrl_pkg::DONE;
                else if (out_q.prog_full) state_next = gen_ctrl_pkg::PAUSE;
            end
            gen_ctrl_pkg::PAUSE: begin
                if (finished) state_next = gen_ctrl_pkg::DONE;
                else if (!out_q.prog_full) state_next = gen_ctrl_pkg::BUSY;
            end
            gen_ctrl_pkg::DONE:       state_next = gen_ctrl_pkg::IDLE;
            default:                  state_next = gen_ctrl_pkg::IDLE;
        endcase
    end

    // --------------------
    // State, run and write counter
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state_q <= gen_ctrl_pkg::RESET;
            run     <= 1'b0;
            count_q <= '0;
        end else begin
            state_q <= state_next;
            run     <= (state_next == gen_ctrl_pkg::BUSY);
            if (state_q == gen_ctrl_pkg::SETUP && config_valid) begin
                count_q <= '0;
            end else begin
                count_q <= count_next;
            end
        end
    end

    // Configuration stays until the next job captures a new one
    always_ff @(posedge ap_clk) begin
        if (state_q == gen_ctrl_pkg::SETUP && config_valid) begin
            cfg_q <= config_word;
        end
    end

    assign forward_value          = cfg_q.forward_value;
    assign configure_memory_setup = (state_q == gen_ctrl_pkg::SETUP_REQ);
    assign done                   = (state_q == gen_ctrl_pkg::DONE);

    // Output writes belong to an active job
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        out_q.wr_en |-> (state_q == gen_ctrl_pkg::BUSY || state_q == gen_ctrl_pkg::PAUSE))
        else $error("output FIFO write outside a job");

endmodule : forward_sequencer

// ==== logic/forward_data_generator.sv ====
// Forward-data generator top level.
// Registers every input and output once, buffers response packets in an
// input FIFO and hands rebased packets to downstream through an output FIFO.

`timescale 1ns/1ps

module forward_data_generator (
    input  logic                                ap_clk,
    input  logic                                areset,
    input  logic                                descriptor_valid,
    input  logic                                config_rd_en,
    input  logic                                config_valid,
    input  logic [forward_pkg::id_w-1:0]        config_forward_value,
    input  logic [gen_ctrl_pkg::count_w-1:0]    config_packet_count,
    input  logic                                response_valid,
    input  logic [forward_pkg::id_w-1:0]        response_from_id,
    input  logic [forward_pkg::id_w-1:0]        response_to_id,
    input  logic [forward_pkg::data_w-1:0]      response_data,
    input  logic                                response_rd_en,
    input  logic                                request_rd_en,
    output logic                                response_full,
    output logic                                response_prog_full,
    output logic                                request_valid,
    output logic [forward_pkg::id_w-1:0]        request_from_id,
    output logic [forward_pkg::id_w-1:0]        request_to_id,
    output logic [forward_pkg::data_w-1:0]      request_data,
    output logic                                configure_memory_setup,
    output logic                                done
);

    logic                       areset_generator;
    logic                       descriptor_valid_q;
    logic                       config_rd_en_q;
    logic                       config_valid_q;
    gen_ctrl_pkg::fwd_config_t  config_q;
    logic                       response_valid_q;
    forward_pkg::packet_t       response_q;
    logic                       response_rd_en_q;
    logic                       request_rd_en_q;
    logic                       run;
    logic                       setup_int;
    logic                       done_int;
    forward_pkg::fwd_id_t       forward_value;

    packet_fifo_if in_q ();
    packet_fifo_if out_q ();

    // --------------------
    // Input registers
    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            descriptor_valid_q <= 1'b0;
            config_rd_en_q     <= 1'b0;
            config_valid_q     <= 1'b0;
            response_valid_q   <= 1'b0;
            response_rd_en_q   <= 1'b0;
            request_rd_en_q    <= 1'b0;
        end else begin
            descriptor_valid_q <= descriptor_valid;
            config_rd_en_q     <= config_rd_en;
            config_valid_q     <= config_valid;
            response_valid_q   <= response_valid;
            response_rd_en_q   <= response_rd_en;
            request_rd_en_q    <= request_rd_en;
        end
    end

    // Payloads packed into structs on the way in
    always_ff @(posedge ap_clk) begin
        config_q.forward_value <= config_forward_value;
        config_q.packet_count  <= config_packet_count;
        response_q.from_id     <= response_from_id;
        response_q.to_id       <= response_to_id;
        response_q.data        <= response_data;
    end

    assign in_q.wr_en  = response_valid_q;
    assign in_q.din    = response_q;
    assign out_q.rd_en = request_rd_en_q && !out_q.empty;

    // --------------------
    // Datapath and control
    packet_fifo in_fifo_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .q                (in_q.fifo)
    );

    forward_rebase forward_rebase_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .run              (run),
        .response_rd_en   (response_rd_en_q),
        .forward_value    (forward_value),
        .in_q             (in_q.reader),
        .out_q            (out_q.writer)
    );

    packet_fifo out_fifo_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .q                (out_q.fifo)
    );

    forward_sequencer forward_sequencer_i (
        .ap_clk                 (ap_clk),
        .areset_generator       (areset_generator),
        .descriptor_valid       (descriptor_valid_q),
        .config_rd_en           (config_rd_en_q),
        .config_valid           (config_valid_q),
        .config_word            (config_q),
        .out_q                  (out_q.monitor),
        .run                    (run),
        .configure_memory_setup (setup_int),
        .done                   (done_int),
        .forward_value          (forward_value)
    );

    // --------------------
    // Output registers
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            response_full          <= 1'b0;
            response_prog_full     <= 1'b0;
            request_valid          <= 1'b0;
            configure_memory_setup <= 1'b0;
            done                   <= 1'b0;
        end else begin
            response_full          <= in_q.full;
            response_prog_full     <= in_q.prog_full;
            request_valid          <= out_q.valid;
            configure_memory_setup <= setup_int;
            done                   <= done_int;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_from_id <= out_q.dout.from_id;
        request_to_id   <= out_q.dout.to_id;
        request_data    <= out_q.dout.data;
    end

endmodule : forward_data_generator

// ==== test/forward_data_generator_tb.sv ====
// Testbench for the forward-data generator.
// Runs three jobs back to back with random offsets, random IDs and long
// stretches of output back-pressure. A queue model rebases each pushed packet
// and is compared with every request_valid output. A cycle limit, worked out
// from the job sizes, ends a run that hangs.

`timescale 1ns/1ps

module forward_data_generator_tb;

    localparam int num_jobs = 3;

    logic                                   ap_clk;
    logic                                   areset;
    logic                                   descriptor_valid;
    logic                                   config_rd_en;
    logic                                   config_valid;
    logic [forward_pkg::id_w-1:0]           config_forward_value;
    logic [gen_ctrl_pkg::count_w-1:0]       config_packet_count;
    logic                                   response_valid;
    logic [forward_pkg::id_w-1:0]           response_from_id;
    logic [forward_pkg::id_w-1:0]           response_to_id;
    logic [forward_pkg::data_w-1:0]         response_data;
    logic                                   response_rd_en;
    logic                                   request_rd_en;
    logic                                   response_full;
    logic                                   response_prog_full;
    logic                                   request_valid;
    logic [forward_pkg::id_w-1:0]           request_from_id;
    logic [forward_pkg::id_w-1:0]           request_to_id;
    logic [forward_pkg::data_w-1:0]         request_data;
    logic                                   configure_memory_setup;
    logic                                   done;

    integer                     seed;
    int                         errors = 0;
    int                         tests_passed = 0;
    int                         tests_failed = 0;
    int                         cycles = 0;
    int                         cycle_limit = 0;
    int                         hold_left = 0;
    int                         done_seen = 0;
    int                         setup_seen = 0;
    int                         rx_count = 0;
    logic                       configured = 1'b0;
    logic                       drain = 1'b0;
    forward_pkg::packet_t       exp_q[$];
    int                         job_count[num_jobs];
    logic [7:0]                 job_offset[num_jobs];

    forward_data_generator forward_data_generator_i (.*);

    initial ap_clk = 1'b0;
    always #2 ap_clk = ~ap_clk;

    // --------------------
    // Run length guard
    always @(posedge ap_clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    // IDs below the offset saturate at zero
    function automatic logic [7:0] expected_id(input logic [7:0] id, input logic [7:0] off);
        if (id < off) begin
            return 8'd0;
        end
        return id - off;
    endfunction

    // One falling edge with new back-pressure and pop-enable levels
    task automatic step();
        @(negedge ap_clk);
        if (hold_left == 0) begin
            if (($random(seed) & 3) == 0) begin
                request_rd_en = 1'b0;
                hold_left     = 20 + ($random(seed) & 31);
            end else begin
                request_rd_en = 1'b1;
                hold_left     = 1 + ($random(seed) & 15);
            end
        end else begin
            hold_left--;
        end
        if (drain) begin
            request_rd_en = 1'b1;
        end
        response_rd_en = (($random(seed) & 7) != 0);
    endtask

    task automatic push_packet(input int job);
        forward_pkg::packet_t   pkt;
        forward_pkg::packet_t   exp;
        // Stop short of the input FIFO limit since status comes back late
        while (response_prog_full) begin
            step();
        end
        pkt.from_id      = 8'($random(seed));
        pkt.to_id        = 8'($random(seed));
        pkt.data         = 32'($random(seed));
        response_valid   = 1'b1;
        response_from_id = pkt.from_id;
        response_to_id   = pkt.to_id;
        response_data    = pkt.data;
        exp.from_id      = expected_id(pkt.from_id, job_offset[job]);
        exp.to_id        = expected_id(pkt.to_id, job_offset[job]);
        exp.data         = pkt.data;
        exp_q.push_back(exp);
        step();
        response_valid   = 1'b0;
    endtask

    task automatic expect_low(input string name, input logic value);
        assert (value === 1'b0) else begin
            $display("Fail at %0t: %s got %b expected 0", $time, name, value);
            errors++;
        end
    endtask

    task automatic expect_count(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed", name);
        end
    endtask

    // --------------------
    // One job runs setup, early packets, configuration, data and done
    task automatic run_job(input int j);
        int     errs_before;
        int     n;
        int     pre;
        int     waited;
        string  tag;
        n           = job_count[j];
        tag         = $sformatf("job %0d", j);
        errs_before = errors;
        configured  = 1'b0;
        done_seen   = 0;
        setup_seen  = 0;
        rx_count    = 0;
        descriptor_valid = 1'b1;
        step();
        descriptor_valid = 1'b0;
        step();
        config_rd_en = 1'b1;
        step();
        config_rd_en = 1'b0;
        while (setup_seen == 0) begin
            step();
        end
        // Packets pushed now must wait for the configuration
        pre = (n < 4) ? n : 4;
        for (int i = 0; i < pre; i++) begin
            push_packet(j);
        end
        repeat (12) step();
        expect_count("configure_memory_setup pulses", setup_seen, 1);
        report_test({tag, " setup"}, errs_before);

        errs_before          = errors;
        config_forward_value = job_offset[j];
        config_packet_count  = 16'(n);
        config_valid         = 1'b1;
        configured           = 1'b1;
        step();
        config_valid = 1'b0;
        for (int i = pre; i < n; i++) begin
            push_packet(j);
        end
        while (done_seen == 0) begin
            step();
        end
        // Everything that done counted already sits in the output FIFO
        drain  = 1'b1;
        waited = 0;
        while (exp_q.size() != 0 && waited < gen_ctrl_pkg::fifo_depth + 8) begin
            step();
            waited++;
        end
        drain = 1'b0;
        repeat (12) step();
        expect_count("request_valid count", rx_count, n);
        report_test({tag, " data"}, errs_before);

        errs_before = errors;
        expect_count("done pulses", done_seen, 1);
        expect_count("configure_memory_setup pulses", setup_seen, 1);
        report_test({tag, " done"}, errs_before);
    endtask

    // --------------------
    // Output monitor sampled away from the active edge
    always @(negedge ap_clk) begin
        forward_pkg::packet_t   exp;
        if (done === 1'b1) begin
            done_seen++;
        end
        if (configure_memory_setup === 1'b1) begin
            setup_seen++;
        end
        if (request_valid === 1'b1) begin
            assert (configured) else begin
                $display("request_valid rose before the job was configured");
                errors++;
            end
            if (exp_q.size() == 0) begin
                $display("request_valid with no packet left in the model");
                errors++;
            end else begin
                exp = exp_q.pop_front();
                rx_count++;
                assert (request_from_id == exp.from_id) else begin
                    $display("Fail at %0t: request_from_id got %h expected %h",
                             $time, request_from_id, exp.from_id);
                    errors++;
                end
                assert (request_to_id == exp.to_id) else begin
                    $display("Fail at %0t: request_to_id got %h expected %h",
                             $time, request_to_id, exp.to_id);
                    errors++;
                end
                assert (request_data == exp.data) else begin
                    $display("Fail at %0t: request_data got %h expected %h",
                             $time, request_data, exp.data);
                    errors++;
                end
            end
        end
    end

    initial begin
        int errs_before;
        seed                 = 32'h6823685f;
        areset               = 1'b1;
        descriptor_valid     = 1'b0;
        config_rd_en         = 1'b0;
        config_valid         = 1'b0;
        config_forward_value = '0;
        config_packet_count  = '0;
        response_valid       = 1'b0;
        response_from_id     = '0;
        response_to_id       = '0;
        response_data        = '0;
        response_rd_en       = 1'b0;
        request_rd_en        = 1'b0;

        // Middle job is empty
        job_count[0] = 20 + ($random(seed) & 31);
        job_count[1] = 0;
        job_count[2] = 20 + ($random(seed) & 31);
        cycle_limit  = 300;
        for (int j = 0; j < num_jobs; j++) begin
            job_offset[j] = 8'($random(seed));
            cycle_limit   = cycle_limit + job_count[j] * 64 + 200;
        end

        repeat (16) @(negedge ap_clk);
        areset = 1'b0;

        errs_before = errors;
        repeat (8) begin
            step();
            expect_low("request_valid", request_valid);
            expect_low("configure_memory_setup", configure_memory_setup);
            expect_low("done", done);
            expect_low("response_full", response_full);
            expect_low("response_prog_full", response_prog_full);
        end
        report_test("reset state", errs_before);

        for (int j = 0; j < num_jobs; j++) begin
            run_job(j);
        end

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : forward_data_generator_tb

// ==== list.f ====
logic/forward_pkg.sv
logic/gen_ctrl_pkg.sv
logic/packet_fifo_if.sv
logic/packet_fifo.sv
logic/forward_rebase.sv
logic/forward_sequencer.sv
logic/forward_data_generator.sv
test/forward_data_generator_tb.sv

// ==== Makefile ====
# Verilator build and run for the forward-data generator testbench

TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= forward_data_generator_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL) and run the simulation"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "No errors" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
